//--- hw/lsq_pkg.sv
// whole 32-bit words only; both queue depths must be powers of two matching the index widths
package lsq_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    localparam int lq_depth  = 4;
    localparam int sq_depth  = 4;
    localparam int lq_idx_w  = 2;
    localparam int sq_idx_w  = 2;
    // wide enough to hold a full store count
    localparam int sq_cnt_w  = 3;
    localparam int addr_w    = 6;
    localparam int data_w    = 32;
    localparam int mem_words = 2 ** addr_w;

    // load slot states
    localparam logic [1:0] ld_wait = 2'd0;
    localparam logic [1:0] ld_mem  = 2'd1;
    localparam logic [1:0] ld_rd   = 2'd2;
    localparam logic [1:0] ld_done = 2'd3;

    //////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////
    typedef struct packed {
        logic valid;
        logic is_store;
    } disp_t;

    // slot is a load or a store slot, both index widths are equal
    typedef struct packed {
        logic                valid;
        logic                is_store;
        logic [lq_idx_w-1:0] slot;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   data;
    } exec_t;

    typedef struct packed {
        logic              valid;
        logic              addr_ok;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } sq_entry_t;

    typedef struct packed {
        sq_entry_t [sq_depth-1:0] entries;
        logic [sq_idx_w-1:0]      head;
        logic [sq_cnt_w-1:0]      count;
    } sq_view_t;

    // older counts the stores still queued ahead of this load
    typedef struct packed {
        logic                valid;
        logic                addr_ok;
        logic [1:0]          state;
        logic [addr_w-1:0]   addr;
        logic [sq_idx_w-1:0] sq_tail;
        logic [sq_cnt_w-1:0] older;
    } lq_entry_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [lq_idx_w-1:0] slot;
        logic [data_w-1:0]   value;
    } ld_result_t;

endpackage

//--- hw/load_queue.sv
// results leave in program order from the head; one memory read in flight at a time
module load_queue import lsq_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  disp_t      disp,
    input  exec_t      exec,
    input  sq_view_t   sq_view,
    output mem_req_t   ld_req,
    input  logic       ld_gnt,
    input  mem_rsp_t   mem_rsp,
    output ld_result_t ld_result,
    output logic       lq_credit
);

    lq_entry_t [lq_depth-1:0] ent, n_ent;
    logic [data_w-1:0]        val [lq_depth];
    logic [data_w-1:0]        n_val [lq_depth];
    logic [lq_idx_w-1:0]      lq_head, n_head;
    logic [lq_idx_w-1:0]      lq_tail, n_tail;
    logic [sq_idx_w-1:0]      sq_head_q;
    logic                     rd_pend, n_rd_pend;
    logic                     rd_wait, n_rd_wait;
    logic [lq_idx_w-1:0]      rd_slot, n_rd_slot;
    ld_result_t               n_res;
    logic                     deliver;
    logic                     sq_drain;

    // store head moved, so the oldest queued store has been written
    assign sq_drain = (sq_view.head != sq_head_q);

    assign ld_req = '{valid: rd_pend && !rd_wait, write: 1'b0,
                      addr: ent[rd_slot].addr, data: '0};

    always_comb begin
        logic [sq_cnt_w-1:0] eff;
        logic                all_ok;
        logic                hit;
        logic [sq_idx_w-1:0] pos;
        logic [data_w-1:0]   fwd;
        logic [lq_idx_w-1:0] idx;
        logic                found;
        logic [lq_idx_w-1:0] pick;

        n_ent     = ent;
        n_val     = val;
        n_head    = lq_head;
        n_tail    = lq_tail;
        n_rd_pend = rd_pend;
        n_rd_wait = rd_wait;
        n_rd_slot = rd_slot;
        n_res     = '0;
        deliver   = 1'b0;
        eff       = '0;
        all_ok    = 1'b0;
        hit       = 1'b0;
        pos       = '0;
        fwd       = '0;
        idx       = '0;
        found     = 1'b0;
        pick      = '0;

        //////////////////////////////////////////////////
        // forwarding scan, youngest older store first
        //////////////////////////////////////////////////
        for (int i = 0; i < lq_depth; i++) begin
            eff = ent[i].older;
            if (sq_drain && eff != '0) begin
                eff = eff - 1'b1;
            end
            n_ent[i].older = eff;
            if (ent[i].valid && ent[i].addr_ok && ent[i].state == ld_wait) begin
                all_ok = 1'b1;
                hit    = 1'b0;
                fwd    = '0;
                for (int k = 1; k <= sq_depth; k++) begin
                    if (k <= int'(eff)) begin
                        pos = ent[i].sq_tail - sq_idx_w'(k);
                        if (!sq_view.entries[pos].addr_ok) begin
                            all_ok = 1'b0;
                        end else if (!hit && sq_view.entries[pos].addr == ent[i].addr) begin
                            hit = 1'b1;
                            fwd = sq_view.entries[pos].data;
                        end
                    end
                end
                // an older store without an address keeps the load waiting
                if (all_ok && hit) begin
                    n_ent[i].state = ld_done;
                    n_val[i]       = fwd;
                end else if (all_ok) begin
                    n_ent[i].state = ld_mem;
                end
            end
        end

        if (exec.valid && !exec.is_store) begin
            n_ent[exec.slot].addr_ok = 1'b1;
            n_ent[exec.slot].addr    = exec.addr;
        end

        //////////////////////////////////////////////////
        // memory read
        //////////////////////////////////////////////////
        if (ld_req.valid && ld_gnt) begin
            n_rd_wait = 1'b1;
        end
        if (mem_rsp.valid) begin
            n_ent[rd_slot].state = ld_done;
            n_val[rd_slot]       = mem_rsp.data;
            n_rd_pend            = 1'b0;
            n_rd_wait            = 1'b0;
        end else if (!rd_pend) begin
            // oldest load that missed the store queue
            for (int k = 0; k < lq_depth; k++) begin
                idx = lq_head + lq_idx_w'(k);
                if (!found && ent[idx].valid && ent[idx].state == ld_mem) begin
                    found = 1'b1;
                    pick  = idx;
                end
            end
            if (found) begin
                n_ent[pick].state = ld_rd;
                n_rd_pend         = 1'b1;
                n_rd_slot         = pick;
            end
        end

        // head delivers as soon as its value is known
        if (n_ent[lq_head].valid && n_ent[lq_head].state == ld_done) begin
            deliver              = 1'b1;
            n_res                = '{valid: 1'b1, slot: lq_head, value: n_val[lq_head]};
            n_ent[lq_head].valid = 1'b0;
            n_ent[lq_head].state = ld_wait;
            n_head               = lq_head + 1'b1;
        end

        if (disp.valid && !disp.is_store) begin
            n_ent[lq_tail] = '{valid: 1'b1, addr_ok: 1'b0, state: ld_wait, addr: '0,
                               sq_tail: sq_view.head + sq_view.count[sq_idx_w-1:0],
                               older: sq_view.count};
            n_tail         = lq_tail + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent       <= '0;
            lq_head   <= '0;
            lq_tail   <= '0;
            sq_head_q <= '0;
            rd_pend   <= 1'b0;
            rd_wait   <= 1'b0;
            rd_slot   <= '0;
            ld_result <= '0;
            lq_credit <= 1'b0;
        end else begin
            ent       <= n_ent;
            lq_head   <= n_head;
            lq_tail   <= n_tail;
            sq_head_q <= sq_view.head;
            rd_pend   <= n_rd_pend;
            rd_wait   <= n_rd_wait;
            rd_slot   <= n_rd_slot;
            ld_result <= n_res;
            lq_credit <= deliver;
        end
    end

    // load values
    always_ff @(posedge clock) begin
        val <= n_val;
    end

endmodule

//--- hw/store_queue.sv
// commit must only name a store whose address and data are known; writes leave in order
module store_queue import lsq_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  disp_t    disp,
    input  exec_t    exec,
    input  logic     commit,
    output sq_view_t sq_view,
    output mem_req_t st_req,
    input  logic     st_gnt,
    output logic     sq_credit
);

    sq_entry_t [sq_depth-1:0] ent, n_ent;
    logic [sq_idx_w-1:0]      sq_head, n_head;
    logic [sq_idx_w-1:0]      sq_tail, n_tail;
    logic [sq_cnt_w-1:0]      sq_count, n_count;
    // committed stores still waiting for their write
    logic [sq_cnt_w-1:0]      cmt_count, n_cmt;
    logic                     alloc;
    logic                     drain;

    assign alloc = disp.valid && disp.is_store;
    assign drain = st_req.valid && st_gnt;

    assign sq_credit = drain;
    assign sq_view   = '{entries: ent, head: sq_head, count: sq_count};

    //////////////////////////////////////////////////
    // write port, head store once committed
    //////////////////////////////////////////////////
    assign st_req = '{valid: cmt_count != '0, write: 1'b1,
                      addr: ent[sq_head].addr, data: ent[sq_head].data};

    always_comb begin
        n_ent   = ent;
        n_head  = sq_head;
        n_tail  = sq_tail;
        n_count = sq_count + sq_cnt_w'(alloc) - sq_cnt_w'(drain);
        n_cmt   = cmt_count + sq_cnt_w'(commit) - sq_cnt_w'(drain);

        if (exec.valid && exec.is_store) begin
            n_ent[exec.slot].addr_ok = 1'b1;
            n_ent[exec.slot].addr    = exec.addr;
            n_ent[exec.slot].data    = exec.data;
        end

        if (drain) begin
            n_ent[sq_head] = '0;
            n_head         = sq_head + 1'b1;
        end

        // a full queue may refill the slot freed in this same cycle
        if (alloc) begin
            n_ent[sq_tail] = '{valid: 1'b1, addr_ok: 1'b0, addr: '0, data: '0};
            n_tail         = sq_tail + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent       <= '0;
            sq_head   <= '0;
            sq_tail   <= '0;
            sq_count  <= '0;
            cmt_count <= '0;
        end else begin
            ent       <= n_ent;
            sq_head   <= n_head;
            sq_tail   <= n_tail;
            sq_count  <= n_count;
            cmt_count <= n_cmt;
        end
    end

endmodule

//--- hw/mem_arbiter.sv
// requesters must hold a request until granted; one grant per cycle at most
module mem_arbiter import lsq_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  mem_req_t ld_req,
    input  mem_req_t st_req,
    output logic     ld_gnt,
    output logic     st_gnt,
    output mem_req_t mem_req
);

    // load side won the last contested or single grant
    logic last_ld;

    // on a tie the side that did not win last time goes first
    assign ld_gnt = ld_req.valid && (!st_req.valid || !last_ld);
    assign st_gnt = st_req.valid && !ld_gnt;

    always_comb begin
        if (ld_gnt) begin
            mem_req = ld_req;
        end else if (st_gnt) begin
            mem_req = st_req;
        end else begin
            mem_req = '0;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            last_ld <= 1'b0;
        end else if (ld_gnt || st_gnt) begin
            last_ld <= ld_gnt;
        end
    end

endmodule

//--- hw/data_mem.sv
// single port, one request per cycle; read data returns one cycle after the request
module data_mem import lsq_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    logic [data_w-1:0] mem [mem_words];

    //////////////////////////////////////////////////
    // word array and read register
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
            mem_rsp <= '0;
        end else begin
            if (mem_req.valid && mem_req.write) begin
                mem[mem_req.addr] <= mem_req.data;
            end
            // only reads answer
            mem_rsp.valid <= mem_req.valid && !mem_req.write;
            mem_rsp.data  <= mem[mem_req.addr];
        end
    end

endmodule

//--- hw/lsq_top.sv
// dispatcher owns the credits; commit only after every older load has returned
module lsq_top import lsq_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  disp_t      disp,
    input  exec_t      exec,
    input  logic       commit,
    output ld_result_t ld_result,
    output logic       lq_credit,
    output logic       sq_credit
);

    sq_view_t sq_view;
    mem_req_t ld_req;
    mem_req_t st_req;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     ld_gnt;
    logic     st_gnt;

    load_queue u_lq (
        .clock     (clock),
        .rst_n     (rst_n),
        .disp      (disp),
        .exec      (exec),
        .sq_view   (sq_view),
        .ld_req    (ld_req),
        .ld_gnt    (ld_gnt),
        .mem_rsp   (mem_rsp),
        .ld_result (ld_result),
        .lq_credit (lq_credit)
    );

    store_queue u_sq (
        .clock     (clock),
        .rst_n     (rst_n),
        .disp      (disp),
        .exec      (exec),
        .commit    (commit),
        .sq_view   (sq_view),
        .st_req    (st_req),
        .st_gnt    (st_gnt),
        .sq_credit (sq_credit)
    );

    // shared memory port
    mem_arbiter u_arb (
        .clock   (clock),
        .rst_n   (rst_n),
        .ld_req  (ld_req),
        .st_req  (st_req),
        .ld_gnt  (ld_gnt),
        .st_gnt  (st_gnt),
        .mem_req (mem_req)
    );

    data_mem u_mem (
        .clock   (clock),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

//--- verification/lsq_sva.sv
// bound twice; unused inputs of an instance are tied low by its bind
module lsq_sva import lsq_pkg::*; (
    input logic                clock,
    input logic                rst_n,
    input logic                ld_req_v,
    input logic                st_req_v,
    input logic                ld_gnt,
    input logic                st_gnt,
    input logic                head_ok,
    input logic [sq_cnt_w-1:0] sq_count,
    input logic [sq_cnt_w-1:0] cmt_count
);

    // a requester that loses a tie holds and wins the next cycle
    ld_no_starve: assert property (@(posedge clock) disable iff (!rst_n)
        ld_req_v && !ld_gnt |=> ld_gnt)
        else $error("load request passed over two cycles in a row");

    st_no_starve: assert property (@(posedge clock) disable iff (!rst_n)
        st_req_v && !st_gnt |=> st_gnt)
        else $error("store request passed over two cycles in a row");

    // head store sent to memory was allocated and executed
    head_known: assert property (@(posedge clock) disable iff (!rst_n)
        st_req_v |-> head_ok)
        else $error("store write requested before its address and data were known");

    store_count_limit: assert property (@(posedge clock) disable iff (!rst_n)
        sq_count <= sq_cnt_w'(sq_depth))
        else $error("store queue count above its depth");

    commit_within_queue: assert property (@(posedge clock) disable iff (!rst_n)
        cmt_count <= sq_count)
        else $error("more committed stores than queued stores");

endmodule

bind mem_arbiter lsq_sva arb_sva (.clock(clock), .rst_n(rst_n), .ld_req_v(ld_req.valid),
    .st_req_v(1'b0), .ld_gnt(ld_gnt), .st_gnt(1'b0), .head_ok(1'b0), .sq_count('0),
    .cmt_count('0));

bind store_queue lsq_sva sq_sva (.clock(clock), .rst_n(rst_n), .ld_req_v(1'b0),
    .st_req_v(st_req.valid), .ld_gnt(1'b0), .st_gnt(st_gnt),
    .head_ok(ent[sq_head].valid && ent[sq_head].addr_ok), .sq_count(sq_count),
    .cmt_count(cmt_count));

//--- verification/lsq_checker.sv
// loads must leave in program order; reads the operation file from the project root
module lsq_checker import lsq_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  ld_result_t ld_result,
    input  logic       lq_credit,
    input  logic       sq_credit,
    input  logic       finish_req,
    output int         errors,
    output logic       done
);

    logic [31:0]       words [0:191];
    logic [data_w-1:0] ref_mem [mem_words];
    logic [data_w-1:0] expect_q [$];
    int                n_loads;
    int                n_stores;
    int                seen;
    int                lq_cnt;
    int                sq_cnt;

    //////////////////////////////////////////////////
    // program-order reference
    //////////////////////////////////////////////////
    initial begin
        errors = 0;
        done = 1'b0;
        n_loads = 0;
        n_stores = 0;
        seen = 0;
        lq_cnt = 0;
        sq_cnt = 0;
        for (int i = 0; i < 192; i++) begin
            words[i] = 32'hffff_ffff;
        end
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = '0;
        end
        $readmemh("verification/lsq_input.txt", words);
        for (int i = 0; i < 64; i++) begin
            if (words[3*i] == 32'd1) begin
                ref_mem[words[3*i+1][addr_w-1:0]] = words[3*i+2];
                n_stores++;
            end else if (words[3*i] == 32'd0) begin
                expect_q.push_back(ref_mem[words[3*i+1][addr_w-1:0]]);
                n_loads++;
            end else begin
                break;
            end
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clock) begin
        if (rst_n && !done) begin
            if (ld_result.valid) begin
                if (seen >= n_loads) begin
                    $display("load result seen with no load outstanding at %0t", $time);
                    errors++;
                end else begin
                    if (ld_result.value !== expect_q[seen]) begin
                        $display("[ERROR] %0t ld_result.value expected %h got %h",
                                 $time, expect_q[seen], ld_result.value);
                        errors++;
                    end
                    if (ld_result.slot !== lq_idx_w'(seen)) begin
                        $display("[ERROR] %0t ld_result.slot expected %0d got %0d",
                                 $time, lq_idx_w'(seen), ld_result.slot);
                        errors++;
                    end
                end
                seen++;
            end
            lq_cnt += int'(lq_credit);
            sq_cnt += int'(sq_credit);
        end
    end

    //////////////////////////////////////////////////
    // closing counts
    //////////////////////////////////////////////////
    always @(posedge finish_req) begin
        if (seen != n_loads) begin
            $display("[ERROR] %0t ld_result count expected %0d got %0d", $time, n_loads, seen);
            errors++;
        end
        if (lq_cnt != n_loads) begin
            $display("[ERROR] %0t lq_credit count expected %0d got %0d", $time, n_loads, lq_cnt);
            errors++;
        end
        if (sq_cnt != n_stores) begin
            $display("[ERROR] %0t sq_credit count expected %0d got %0d", $time, n_stores, sq_cnt);
            errors++;
        end
        $display("checker: %0d loads checked, %0d lq credits, %0d sq credits, %0d errors",
                 seen, lq_cnt, sq_cnt, errors);
        done = 1'b1;
    end

endmodule

//--- verification/lsq_tb.sv
// stimulus comes from the operation file; run make from the project root
module lsq_tb import lsq_pkg::*; ();

    logic       clock;
    logic       rst_n;
    disp_t      disp;
    exec_t      exec;
    logic       commit;
    ld_result_t ld_result;
    logic       lq_credit;
    logic       sq_credit;
    logic       finish_req;
    int         chk_errors;
    logic       chk_done;

    logic [31:0]       words [0:191];
    logic              kind [64];
    logic [addr_w-1:0] op_addr [64];
    logic [data_w-1:0] op_data [64];
    int                slot_of [64];
    int                loads_before [64];
    bit                exec_done [64];
    int                pend [$];
    integer            seed;
    int                n_ops, n_loads, n_stores;
    int                lq_cred, sq_cred;
    int                disp_ptr, cm_ptr, commits, loads_ret, tb_errors;

    lsq_top dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .disp      (disp),
        .exec      (exec),
        .commit    (commit),
        .ld_result (ld_result),
        .lq_credit (lq_credit),
        .sq_credit (sq_credit)
    );

    lsq_checker chk (
        .clock      (clock),
        .rst_n      (rst_n),
        .ld_result  (ld_result),
        .lq_credit  (lq_credit),
        .sq_credit  (sq_credit),
        .finish_req (finish_req),
        .errors     (chk_errors),
        .done       (chk_done)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // operation list and slot numbering
    //////////////////////////////////////////////////
    task automatic load_ops();
        int lq_n;
        int sq_n;
        lq_n = 0;
        sq_n = 0;
        n_ops = 0;
        for (int i = 0; i < 192; i++) begin
            words[i] = 32'hffff_ffff;
        end
        $readmemh("verification/lsq_input.txt", words);
        while (n_ops < 64 && (words[3*n_ops] == 32'd0 || words[3*n_ops] == 32'd1)) begin
            kind[n_ops] = words[3*n_ops][0];
            op_addr[n_ops] = words[3*n_ops+1][addr_w-1:0];
            op_data[n_ops] = words[3*n_ops+2];
            loads_before[n_ops] = lq_n;
            slot_of[n_ops] = kind[n_ops] ? sq_n % sq_depth : lq_n % lq_depth;
            if (kind[n_ops]) begin
                sq_n++;
            end else begin
                lq_n++;
            end
            exec_done[n_ops] = 1'b0;
            n_ops++;
        end
        n_loads = lq_n;
        n_stores = sq_n;
    endtask

    // one falling edge: commit, execute, dispatch, then take back credits
    task automatic step();
        bit ld_back;
        bit sq_back;
        int r;
        int idx;
        ld_back = lq_credit;
        sq_back = sq_credit;
        if (ld_result.valid) begin
            loads_ret++;
        end
        disp = '0;
        exec = '0;
        commit = 1'b0;
        while (cm_ptr < n_ops && !kind[cm_ptr]) begin
            cm_ptr++;
        end
        if (cm_ptr < disp_ptr && exec_done[cm_ptr] && loads_ret >= loads_before[cm_ptr]) begin
            commit = 1'b1;
            cm_ptr++;
            commits++;
        end
        if (pend.size() > 0) begin
            r = $unsigned($random(seed)) % pend.size();
            idx = pend[r];
            pend.delete(r);
            exec = '{valid: 1'b1, is_store: kind[idx], slot: lq_idx_w'(slot_of[idx]),
                     addr: op_addr[idx], data: kind[idx] ? op_data[idx] : '0};
            exec_done[idx] = 1'b1;
        end
        if (disp_ptr < n_ops) begin
            idx = disp_ptr;
            if ((kind[idx] && sq_cred > 0) || (!kind[idx] && lq_cred > 0)) begin
                disp = '{valid: 1'b1, is_store: kind[idx]};
                if (kind[idx]) begin
                    sq_cred--;
                end else begin
                    lq_cred--;
                end
                pend.push_back(idx);
                disp_ptr++;
            end
        end
        lq_cred += int'(ld_back);
        sq_cred += int'(sq_back);
        if (lq_cred > lq_depth || sq_cred > sq_depth) begin
            $display("a credit came back with no slot outstanding at %0t", $time);
            tb_errors++;
        end
    endtask

    function automatic bit all_done();
        return disp_ptr == n_ops && loads_ret == n_loads && commits == n_stores &&
               lq_cred == lq_depth && sq_cred == sq_depth;
    endfunction

    initial begin
        seed = 32'hab919c8a;
        rst_n = 1'b0;
        disp = '0;
        exec = '0;
        commit = 1'b0;
        finish_req = 1'b0;
        lq_cred = lq_depth;
        sq_cred = sq_depth;
        disp_ptr = 0;
        cm_ptr = 0;
        commits = 0;
        loads_ret = 0;
        tb_errors = 0;
        load_ops();
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        while (!all_done()) begin
            @(negedge clock);
            step();
        end
        repeat (4) @(negedge clock);
        finish_req = 1'b1;
        wait (chk_done);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog, 40 cycles per operation plus reset
    initial begin
        #1;
        #((n_ops * 40 + 8) * 8);
        $display("operations did not all complete before the watchdog expired");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- verification/lsq_input.txt
// kind addr data: kind 0 is a load, 1 is a store; addr is a word address
// data is the store data in hex and is ignored for loads
0 05 00000000
1 0a 11111111
0 0a 00000000
1 0b 22222222
1 0b 33333333
0 0b 00000000
1 0b 44444444
0 0c 00000000
1 0c 55555555
0 0a 00000000
1 20 aaaa0001
1 21 aaaa0002
0 20 00000000
0 21 00000000
0 22 00000000
1 22 aaaa0003
0 22 00000000
0 05 00000000
1 05 bbbb0001
1 0a cccc0001
0 0a 00000000
0 0b 00000000
0 05 00000000
1 30 dddd0001
0 30 00000000
0 3f 00000000

//--- compile.f
hw/lsq_pkg.sv
hw/load_queue.sv
hw/store_queue.sv
hw/mem_arbiter.sv
hw/data_mem.sv
hw/lsq_top.sv
verification/lsq_sva.sv
verification/lsq_checker.sv
verification/lsq_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lsq_tb
FILELIST = compile.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -Wno-fatal --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir
